// ==== source/cpu_wrapper_pkg.sv ====
package cpu_wrapper_pkg;

  // basic widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   axi_id_t;

  // axi response codes
  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  // levels held by the core for the whole access
  typedef struct packed {
    logic  req;
    logic  write;
    strb_t strb;
    addr_t addr;
    data_t data;
  } core_req_t;

  // one queued access, req level dropped
  typedef struct packed {
    logic  write;
    strb_t strb;
    addr_t addr;
    data_t data;
  } access_req_t;

  // read result back to the core
  typedef struct packed {
    data_t data;
    logic  err;
  } access_rsp_t;

  // master side of axi-lite
  typedef struct packed {
    logic    ar_valid;
    addr_t   ar_addr;
    axi_id_t ar_id;
    logic    aw_valid;
    addr_t   aw_addr;
    axi_id_t aw_id;
    logic    w_valid;
    data_t   w_data;
    strb_t   w_strb;
    logic    r_ready;
    logic    b_ready;
  } axi_req_t;

  // slave side of axi-lite
  typedef struct packed {
    logic       ar_ready;
    logic       aw_ready;
    logic       w_ready;
    logic       r_valid;
    data_t      r_data;
    axi_id_t    r_id;
    logic [1:0] r_resp;
    logic       b_valid;
    axi_id_t    b_id;
    logic [1:0] b_resp;
  } axi_rsp_t;

endpackage

// ==== source/core_port.sv ====
`timescale 1ns/1ns

module core_port (
  input  logic                          clk,
  input  logic                          rst_i,
  // core side
  input  cpu_wrapper_pkg::core_req_t    core_req_i,
  output cpu_wrapper_pkg::data_t        rdata_o,
  output logic                          rerr_o,
  output logic                          stall_o,
  // request fifo
  output logic                          req_push_o,
  output cpu_wrapper_pkg::access_req_t  req_item_o,
  input  logic                          req_full_i,
  // response fifo
  input  cpu_wrapper_pkg::access_rsp_t  rsp_item_i,
  input  logic                          rsp_valid_i,
  output logic                          rsp_pop_o
);

  logic req_rd;
  logic req_wr;
  // read pushed, waiting on response
  logic rd_pending_q;
  logic rd_done;

  assign req_rd = core_req_i.req & ~core_req_i.write;
  assign req_wr = core_req_i.req & core_req_i.write;

  // read finishes when its response sits at the fifo head
  assign rd_done = req_rd & rd_pending_q & rsp_valid_i;

  // posted write goes in at once if there is room
  // a read goes in only once, guarded by the pending flag
  always_comb begin
    req_push_o = 1'b0;
    if (req_wr && !req_full_i) begin
      req_push_o = 1'b1;
    end else if (req_rd && !rd_pending_q && !req_full_i) begin
      req_push_o = 1'b1;
    end
  end

  // core fields straight into the record
  assign req_item_o.write = core_req_i.write;
  assign req_item_o.strb  = core_req_i.strb;
  assign req_item_o.addr  = core_req_i.addr;
  assign req_item_o.data  = core_req_i.data;

  // pending flag set on read push, cleared on completion
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rd_pending_q <= 1'b0;
    end else if (rd_done) begin
      rd_pending_q <= 1'b0;
    end else if (req_rd && !req_full_i) begin
      rd_pending_q <= 1'b1;
    end
  end

  // writes stall only on a full fifo
  // reads stall until the response shows up
  always_comb begin
    stall_o = 1'b0;
    if (req_wr) begin
      stall_o = req_full_i;
    end else if (req_rd) begin
      stall_o = ~rd_done;
    end
  end

  // response consumed in the completion cycle
  assign rsp_pop_o = rd_done;
  assign rdata_o   = rsp_item_i.data;
  assign rerr_o    = rsp_item_i.err;

endmodule

// ==== source/access_fifo.sv ====
`timescale 1ns/1ns

module access_fifo #(
  parameter type item_t     = logic,
  parameter int  FIFO_DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst_i,
  // write side
  input  logic  push_i,
  input  item_t item_i,
  output logic  full_o,
  // read side
  input  logic  pop_i,
  output item_t item_o,
  output logic  valid_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  item_t            mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;
  logic             full_q;
  logic             valid_q;
  logic             do_push;
  logic             do_pop;

  // ignore push on full and pop on empty
  assign do_push = push_i & ~full_q;
  assign do_pop  = pop_i & valid_q;

  always_comb begin
    count_d = count_q;
    if (do_push && !do_pop) begin
      count_d = count_q + CNT_W'(1);
    end else if (do_pop && !do_push) begin
      count_d = count_q - CNT_W'(1);
    end
  end

  // item storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= item_i;
    end
  end

  // pointers wrap at depth and flags follow the next count
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_q   <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      count_q <= count_d;
      full_q  <= (count_d == CNT_W'(FIFO_DEPTH));
      valid_q <= (count_d != '0);
    end
  end

  assign item_o  = mem_q[rd_ptr_q];
  assign full_o  = full_q;
  assign valid_o = valid_q;

endmodule

// ==== source/axi_master.sv ====
`timescale 1ns/1ns

module axi_master #(
  parameter cpu_wrapper_pkg::axi_id_t MASTER_ID = '0
) (
  input  logic                          clk,
  input  logic                          rst_i,
  // request fifo head
  input  cpu_wrapper_pkg::access_req_t  req_item_i,
  input  logic                          req_valid_i,
  output logic                          req_pop_o,
  // response fifo
  output logic                          rsp_push_o,
  output cpu_wrapper_pkg::access_rsp_t  rsp_item_o,
  // axi-lite bus
  output cpu_wrapper_pkg::axi_req_t     axi_req_o,
  input  cpu_wrapper_pkg::axi_rsp_t     axi_rsp_i,
  // sticky bus error on writes
  output logic                          wr_err_o
);

  import cpu_wrapper_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_ar,
    st_r,
    st_aw_w,
    st_b
  } state_t;

  state_t      state_q;
  state_t      state_d;
  // access in flight
  access_req_t cur_q;
  logic        aw_done_q;
  logic        w_done_q;
  logic        aw_fire;
  logic        w_fire;
  logic        wr_err_q;

  assign aw_fire = axi_req_o.aw_valid & axi_rsp_i.aw_ready;
  assign w_fire  = axi_req_o.w_valid & axi_rsp_i.w_ready;

  // take the head only from idle
  assign req_pop_o = (state_q == st_idle) & req_valid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_valid_i) begin
          state_d = req_item_i.write ? st_aw_w : st_ar;
        end
      end
      st_ar: begin
        if (axi_rsp_i.ar_ready) begin
          state_d = st_r;
        end
      end
      st_r: begin
        if (axi_rsp_i.r_valid) begin
          state_d = st_idle;
        end
      end
      st_aw_w: begin
        // both channels done, now or earlier
        if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
          state_d = st_b;
        end
      end
      st_b: begin
        if (axi_rsp_i.b_valid) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= st_idle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      wr_err_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == st_aw_w) begin
        aw_done_q <= aw_done_q | aw_fire;
        w_done_q  <= w_done_q | w_fire;
      end else begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
      if (state_q == st_b && axi_rsp_i.b_valid && axi_rsp_i.b_resp != AXI_RESP_OKAY) begin
        wr_err_q <= 1'b1;
      end
    end
  end

  // payload latch
  always_ff @(posedge clk) begin
    if (req_pop_o) begin
      cur_q <= req_item_i;
    end
  end

  // bus drive
  always_comb begin
    axi_req_o          = '0;
    axi_req_o.ar_valid = (state_q == st_ar);
    axi_req_o.ar_addr  = cur_q.addr;
    axi_req_o.ar_id    = MASTER_ID;
    axi_req_o.aw_valid = (state_q == st_aw_w) & ~aw_done_q;
    axi_req_o.aw_addr  = cur_q.addr;
    axi_req_o.aw_id    = MASTER_ID;
    axi_req_o.w_valid  = (state_q == st_aw_w) & ~w_done_q;
    axi_req_o.w_data   = cur_q.data;
    axi_req_o.w_strb   = cur_q.strb;
    axi_req_o.r_ready  = (state_q == st_r);
    axi_req_o.b_ready  = (state_q == st_b);
  end

  // read result with error flag
  assign rsp_push_o      = (state_q == st_r) & axi_rsp_i.r_valid;
  assign rsp_item_o.data = axi_rsp_i.r_data;
  assign rsp_item_o.err  = (axi_rsp_i.r_resp != AXI_RESP_OKAY);

  assign wr_err_o = wr_err_q;

endmodule

// ==== source/cpu_master_port.sv ====
`timescale 1ns/1ns

module cpu_master_port #(
  parameter cpu_wrapper_pkg::axi_id_t MASTER_ID  = '0,
  parameter int                       FIFO_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst_i,
  // core side
  input  cpu_wrapper_pkg::core_req_t  core_req_i,
  output cpu_wrapper_pkg::data_t      rdata_o,
  output logic                        rerr_o,
  output logic                        stall_o,
  output logic                        wr_err_o,
  // axi-lite bus
  output cpu_wrapper_pkg::axi_req_t   axi_req_o,
  input  cpu_wrapper_pkg::axi_rsp_t   axi_rsp_i
);

  import cpu_wrapper_pkg::*;

  // request path
  logic        req_push;
  access_req_t req_item;
  logic        req_full;
  access_req_t req_head;
  logic        req_valid;
  logic        req_pop;
  // response path
  logic        rsp_push;
  access_rsp_t rsp_item;
  access_rsp_t rsp_head;
  logic        rsp_valid;
  logic        rsp_pop;

  core_port u_core_port (
    .clk         (clk),
    .rst_i       (rst_i),
    .core_req_i  (core_req_i),
    .rdata_o     (rdata_o),
    .rerr_o      (rerr_o),
    .stall_o     (stall_o),
    .req_push_o  (req_push),
    .req_item_o  (req_item),
    .req_full_i  (req_full),
    .rsp_item_i  (rsp_head),
    .rsp_valid_i (rsp_valid),
    .rsp_pop_o   (rsp_pop)
  );

  access_fifo #(
    .item_t     (access_req_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_req_fifo (
    .clk     (clk),
    .rst_i   (rst_i),
    .push_i  (req_push),
    .item_i  (req_item),
    .full_o  (req_full),
    .pop_i   (req_pop),
    .item_o  (req_head),
    .valid_o (req_valid)
  );

  // read results wait here for the core port
  access_fifo #(
    .item_t     (access_rsp_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_rsp_fifo (
    .clk     (clk),
    .rst_i   (rst_i),
    .push_i  (rsp_push),
    .item_i  (rsp_item),
    .full_o  (),
    .pop_i   (rsp_pop),
    .item_o  (rsp_head),
    .valid_o (rsp_valid)
  );

  axi_master #(
    .MASTER_ID (MASTER_ID)
  ) u_axi_master (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_item_i  (req_head),
    .req_valid_i (req_valid),
    .req_pop_o   (req_pop),
    .rsp_push_o  (rsp_push),
    .rsp_item_o  (rsp_item),
    .axi_req_o   (axi_req_o),
    .axi_rsp_i   (axi_rsp_i),
    .wr_err_o    (wr_err_o)
  );

endmodule

// ==== source/cpu_wrapper.sv ====
`timescale 1ns/1ns

module cpu_wrapper #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst_i,
  // instruction port
  input  cpu_wrapper_pkg::core_req_t  inst_req_i,
  output cpu_wrapper_pkg::data_t      inst_rdata_o,
  output logic                        inst_rerr_o,
  output logic                        inst_stall_o,
  output logic                        inst_wr_err_o,
  output cpu_wrapper_pkg::axi_req_t   inst_axi_req_o,
  input  cpu_wrapper_pkg::axi_rsp_t   inst_axi_rsp_i,
  // data port
  input  cpu_wrapper_pkg::core_req_t  data_req_i,
  output cpu_wrapper_pkg::data_t      data_rdata_o,
  output logic                        data_rerr_o,
  output logic                        data_stall_o,
  output logic                        data_wr_err_o,
  output cpu_wrapper_pkg::axi_req_t   data_axi_req_o,
  input  cpu_wrapper_pkg::axi_rsp_t   data_axi_rsp_i
);

  // instruction side, master 0
  cpu_master_port #(
    .MASTER_ID  (4'd0),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_inst_port (
    .clk        (clk),
    .rst_i      (rst_i),
    .core_req_i (inst_req_i),
    .rdata_o    (inst_rdata_o),
    .rerr_o     (inst_rerr_o),
    .stall_o    (inst_stall_o),
    .wr_err_o   (inst_wr_err_o),
    .axi_req_o  (inst_axi_req_o),
    .axi_rsp_i  (inst_axi_rsp_i)
  );

  // data side, master 1
  cpu_master_port #(
    .MASTER_ID  (4'd1),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_data_port (
    .clk        (clk),
    .rst_i      (rst_i),
    .core_req_i (data_req_i),
    .rdata_o    (data_rdata_o),
    .rerr_o     (data_rerr_o),
    .stall_o    (data_stall_o),
    .wr_err_o   (data_wr_err_o),
    .axi_req_o  (data_axi_req_o),
    .axi_rsp_i  (data_axi_rsp_i)
  );

endmodule

// ==== testbench/axi_mem_model.sv ====
`timescale 1ns/1ns

module axi_mem_model #(
  parameter logic [31:0] SEED = 32'hfbdca3eb
) (
  input  logic                       clk,
  input  logic                       rst_i,
  // bus of master 0
  input  cpu_wrapper_pkg::axi_req_t  inst_axi_req_i,
  output cpu_wrapper_pkg::axi_rsp_t  inst_axi_rsp_o,
  // bus of master 1
  input  cpu_wrapper_pkg::axi_req_t  data_axi_req_i,
  output cpu_wrapper_pkg::axi_rsp_t  data_axi_rsp_o
);

  import cpu_wrapper_pkg::*;

  localparam int WORDS = 256;

  // one array behind both buses
  data_t       mem [WORDS];
  axi_req_t    req [2];
  logic        ar_ready [2];
  // aw and w share one ready
  logic        aw_ready [2];
  logic        r_valid [2];
  data_t       r_data [2];
  axi_id_t     r_id [2];
  logic [1:0]  r_resp [2];
  logic        b_valid [2];
  axi_id_t     b_id [2];
  logic [1:0]  b_resp [2];
  int          dly [2];
  logic [31:0] lcg_q;

  assign req[0] = inst_axi_req_i;
  assign req[1] = data_axi_req_i;

  assign inst_axi_rsp_o = {ar_ready[0], aw_ready[0], aw_ready[0], r_valid[0], r_data[0],
                           r_id[0], r_resp[0], b_valid[0], b_id[0], b_resp[0]};
  assign data_axi_rsp_o = {ar_ready[1], aw_ready[1], aw_ready[1], r_valid[1], r_data[1],
                           r_id[1], r_resp[1], b_valid[1], b_id[1], b_resp[1]};

  // lcg step, two upper bits give 0 to 3 cycles
  function automatic int next_delay();
    lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
    return int'(lcg_q[25:24]);
  endfunction

  // only the first 1 KB is backed by the array
  function automatic logic in_range(input addr_t a);
    return a < 32'h400;
  endfunction

  always @(posedge clk) begin : bus_seq
    data_t word;
    if (rst_i) begin
      lcg_q = SEED;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
      for (int p = 0; p < 2; p++) begin
        ar_ready[p] <= 1'b0;
        aw_ready[p] <= 1'b0;
        r_valid[p]  <= 1'b0;
        b_valid[p]  <= 1'b0;
        dly[p]      <= 0;
      end
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (r_valid[p] && req[p].r_ready) begin
          r_valid[p] <= 1'b0;
        end
        if (b_valid[p] && req[p].b_ready) begin
          b_valid[p] <= 1'b0;
        end
        if (ar_ready[p]) begin
          // address taken, data in the next cycle
          ar_ready[p] <= 1'b0;
          r_valid[p]  <= 1'b1;
          r_id[p]     <= req[p].ar_id;
          r_data[p]   <= in_range(req[p].ar_addr) ? mem[req[p].ar_addr[9:2]] : '0;
          r_resp[p]   <= in_range(req[p].ar_addr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end else if (aw_ready[p]) begin
          // aw and w taken together, byte merge into the word
          aw_ready[p] <= 1'b0;
          b_valid[p]  <= 1'b1;
          b_id[p]     <= req[p].aw_id;
          b_resp[p]   <= in_range(req[p].aw_addr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
          if (in_range(req[p].aw_addr)) begin
            word = mem[req[p].aw_addr[9:2]];
            for (int b = 0; b < 4; b++) begin
              if (req[p].w_strb[b]) begin
                word[8*b +: 8] = req[p].w_data[8*b +: 8];
              end
            end
            mem[req[p].aw_addr[9:2]] <= word;
          end
        end else if (req[p].ar_valid || (req[p].aw_valid && req[p].w_valid)) begin
          // count down, then raise ready and draw the next delay
          if (dly[p] != 0) begin
            dly[p] <= dly[p] - 1;
          end else if (req[p].ar_valid) begin
            ar_ready[p] <= 1'b1;
            dly[p]      <= next_delay();
          end else begin
            aw_ready[p] <= 1'b1;
            dly[p]      <= next_delay();
          end
        end
      end
    end
  end

endmodule

// ==== testbench/tb_cpu_wrapper.sv ====
`timescale 1ns/1ns

module tb_cpu_wrapper;

  import cpu_wrapper_pkg::*;

  localparam int          FIFO_DEPTH = 4;
  localparam int          CLK_PERIOD = 8;
  localparam int          RST_CYCLES = 16;
  localparam logic [31:0] SEED       = 32'hfbdca3eb;
  localparam logic        P_INST     = 1'b0;
  localparam logic        P_DATA     = 1'b1;
  localparam axi_id_t     INST_ID    = 4'd0;
  localparam axi_id_t     DATA_ID    = 4'd1;

  // one row of the stimulus table
  typedef struct packed {
    logic  port;
    logic  write;
    strb_t strb;
    addr_t addr;
    data_t data;
    data_t exp_data;
    logic  exp_err;
    logic  exp_wr_err;
  } entry_t;

  logic      clk = 1'b0;
  logic      rst_i;
  core_req_t inst_req;
  core_req_t data_req;
  data_t     inst_rdata;
  data_t     data_rdata;
  logic      inst_rerr;
  logic      data_rerr;
  logic      inst_stall;
  logic      data_stall;
  logic      inst_wr_err;
  logic      data_wr_err;
  axi_req_t  inst_axi_req;
  axi_req_t  data_axi_req;
  axi_rsp_t  inst_axi_rsp;
  axi_rsp_t  data_axi_rsp;
  entry_t    tbl [$];
  // expected memory contents
  data_t     shadow [256];
  int        errors = 0;
  int        checks = 0;
  logic      tbl_ready = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  cpu_wrapper #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk            (clk),
    .rst_i          (rst_i),
    .inst_req_i     (inst_req),
    .inst_rdata_o   (inst_rdata),
    .inst_rerr_o    (inst_rerr),
    .inst_stall_o   (inst_stall),
    .inst_wr_err_o  (inst_wr_err),
    .inst_axi_req_o (inst_axi_req),
    .inst_axi_rsp_i (inst_axi_rsp),
    .data_req_i     (data_req),
    .data_rdata_o   (data_rdata),
    .data_rerr_o    (data_rerr),
    .data_stall_o   (data_stall),
    .data_wr_err_o  (data_wr_err),
    .data_axi_req_o (data_axi_req),
    .data_axi_rsp_i (data_axi_rsp)
  );

  axi_mem_model #(
    .SEED (SEED)
  ) u_mem (
    .clk            (clk),
    .rst_i          (rst_i),
    .inst_axi_req_i (inst_axi_req),
    .inst_axi_rsp_o (inst_axi_rsp),
    .data_axi_req_i (data_axi_req),
    .data_axi_rsp_o (data_axi_rsp)
  );

  // byte lanes with strobe set take the new data
  function automatic data_t merge_strobes(input data_t old, input data_t wdata, input strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic verify_master_id(input axi_id_t got, input axi_id_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic add_entry(input logic port, input logic write, input strb_t strb,
                           input addr_t addr, input data_t data);
    entry_t e;
    e = {port, write, strb, addr, data, 32'h0, 1'b0, 1'b0};
    tbl.push_back(e);
  endtask

  task automatic build_table();
    // write, read back, partial writes
    add_entry(P_DATA, 1'b1, 4'hf, 32'h010, 32'h1122_3344);
    add_entry(P_DATA, 1'b0, 4'h0, 32'h010, '0);
    add_entry(P_DATA, 1'b1, 4'h5, 32'h010, 32'haabb_ccdd);
    add_entry(P_DATA, 1'b0, 4'h0, 32'h010, '0);
    add_entry(P_DATA, 1'b1, 4'h8, 32'h014, 32'hee00_0000);
    add_entry(P_DATA, 1'b0, 4'h0, 32'h014, '0);
    // five posted writes to one word
    for (int k = 0; k < 5; k++) begin
      add_entry(P_DATA, 1'b1, 4'hf, 32'h020, 32'hc0de_0000 + k);
    end
    add_entry(P_DATA, 1'b0, 4'h0, 32'h020, '0);
    // code words stored by the data port
    add_entry(P_DATA, 1'b1, 4'hf, 32'h100, 32'h0000_0013);
    add_entry(P_DATA, 1'b1, 4'hf, 32'h104, 32'h00a0_0093);
    // data read drains both writes before the fetches
    add_entry(P_DATA, 1'b0, 4'h0, 32'h104, '0);
    add_entry(P_INST, 1'b0, 4'h0, 32'h100, '0);
    add_entry(P_INST, 1'b0, 4'h0, 32'h104, '0);
    add_entry(P_INST, 1'b0, 4'h0, 32'h010, '0);
    // reads past the array
    add_entry(P_INST, 1'b0, 4'h0, 32'h400, '0);
    add_entry(P_DATA, 1'b0, 4'h0, 32'h7fc, '0);
    add_entry(P_DATA, 1'b0, 4'h0, 32'hffff_fff0, '0);
    // bad write whose flag shows on the later reads
    add_entry(P_DATA, 1'b1, 4'hf, 32'h400, 32'hdead_beef);
    add_entry(P_DATA, 1'b0, 4'h0, 32'h020, '0);
    add_entry(P_INST, 1'b0, 4'h0, 32'h100, '0);
  endtask

  // walk the table against the shadow memory
  task automatic fill_expected();
    entry_t     e;
    logic [1:0] sticky;
    sticky = 2'b00;
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
    foreach (tbl[i]) begin
      e = tbl[i];
      if (e.write && e.addr < 32'h400) begin
        shadow[e.addr[9:2]] = merge_strobes(shadow[e.addr[9:2]], e.data, e.strb);
      end else if (e.write) begin
        sticky[e.port] = 1'b1;
      end else begin
        e.exp_data   = (e.addr < 32'h400) ? shadow[e.addr[9:2]] : '0;
        e.exp_err    = (e.addr >= 32'h400);
        e.exp_wr_err = sticky[e.port];
      end
      tbl[i] = e;
    end
  endtask

  // hold the request until a cycle without stall
  task automatic run_entry(input int idx);
    entry_t    e;
    core_req_t r;
    int        err_before;
    logic      done;
    e          = tbl[idx];
    err_before = errors;
    r          = {1'b1, e.write, e.strb, e.addr, e.data};
    done       = 1'b0;
    @(posedge clk);
    inst_req <= e.port ? '0 : r;
    data_req <= e.port ? r : '0;
    while (!done) begin
      @(negedge clk);
      done = e.port ? !data_stall : !inst_stall;
    end
    if (!e.write) begin
      check_data(e.port ? data_rdata : inst_rdata, e.exp_data,
                 $sformatf("test %0d rdata", idx));
      check_err(e.port ? data_rerr : inst_rerr, e.exp_err, $sformatf("test %0d rerr", idx));
      check_err(e.port ? data_wr_err : inst_wr_err, e.exp_wr_err,
                $sformatf("test %0d wr_err", idx));
    end
    $display("test %0d: %s port %0d addr %h %s", idx, e.write ? "write" : "read", e.port,
             e.addr, (errors == err_before) ? "ok" : "failed");
  endtask

  // master id seen at every address handshake on both buses
  always @(posedge clk) begin
    if (!rst_i) begin
      if (inst_axi_req.ar_valid && inst_axi_rsp.ar_ready) begin
        verify_master_id(inst_axi_req.ar_id, INST_ID, "inst ar_id");
      end
      if (inst_axi_req.aw_valid && inst_axi_rsp.aw_ready) begin
        verify_master_id(inst_axi_req.aw_id, INST_ID, "inst aw_id");
      end
      if (data_axi_req.ar_valid && data_axi_rsp.ar_ready) begin
        verify_master_id(data_axi_req.ar_id, DATA_ID, "data ar_id");
      end
      if (data_axi_req.aw_valid && data_axi_rsp.aw_ready) begin
        verify_master_id(data_axi_req.aw_id, DATA_ID, "data aw_id");
      end
    end
  end

  initial begin
    rst_i    = 1'b1;
    inst_req = '0;
    data_req = '0;
    build_table();
    fill_expected();
    tbl_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
    // idle after reset
    @(negedge clk);
    check_err(inst_stall, 1'b0, "idle inst stall");
    check_err(data_stall, 1'b0, "idle data stall");
    check_err(inst_wr_err, 1'b0, "reset inst wr_err");
    check_err(data_wr_err, 1'b0, "reset data wr_err");
    $display("test reset: %s", (errors == 0) ? "ok" : "failed");
    foreach (tbl[i]) begin
      run_entry(i);
    end
    @(posedge clk);
    inst_req <= '0;
    data_req <= '0;
    $display("tests %0d, checks %0d, errors %0d", tbl.size() + 1, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // 200 cycles per row on top of reset
  initial begin
    wait (tbl_ready);
    #((RST_CYCLES + tbl.size() * 200) * CLK_PERIOD);
    $display("timeout: the table did not finish, a stall never dropped");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== cpu_wrapper.f ====
source/cpu_wrapper_pkg.sv
source/core_port.sv
source/access_fifo.sv
source/axi_master.sv
source/cpu_master_port.sv
source/cpu_wrapper.sv
testbench/axi_mem_model.sv
testbench/tb_cpu_wrapper.sv

// ==== Bender.yml ====
package:
  name: cpu_wrapper

sources:
  - source/cpu_wrapper_pkg.sv
  - source/core_port.sv
  - source/access_fifo.sv
  - source/axi_master.sv
  - source/cpu_master_port.sv
  - source/cpu_wrapper.sv
  - target: test
    files:
      - testbench/axi_mem_model.sv
      - testbench/tb_cpu_wrapper.sv
